//--- filelist.f
logic/msx_glue_pkg.sv
logic/slot_decoder.sv
logic/memory_map.sv
logic/read_data_mux.sv
logic/msx_bus_glue.sv
tests/msx_bus_glue_properties.sv
tests/msx_bus_glue_tb.sv

//--- logic/memory_map.sv
// ----------------------------------------------------------------------
//	SDRAM memory map
//	Turns slot selection and Z80 address into an SDRAM request
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module memory_map (
	input	msx_glue_pkg::cpu_bus_t		bus,
	input	msx_glue_pkg::slot_sel_t	slot,
	input	logic	[7:0]				segment,
	output	msx_glue_pkg::sdram_req_t	sdram
);
	import msx_glue_pkg::*;

	logic	[SDRAM_AW-14:0]	w_upper;		// Address bits 22..13
	logic					w_hit;			// Some region answers
	logic					w_ram;			// Region is writable
	logic					w_ffff_exp;
	logic					w_cycle;
	logic	[1:0]			w_page;
	logic					w_a13;

	assign w_page	= bus.addr.mem.page;
	assign w_a13	= bus.addr.mem.a13;

	// Subslot register in an expanded slot is not memory
	assign w_ffff_exp	= (bus.addr == SUBSLOT_REG_ADDR) && (slot.sltsl[0] || slot.sltsl[3]);
	assign w_cycle		= !bus.mreq_n && bus.iorq_n && !w_ffff_exp;

	// ------------------------------------------------------------------
	//	Region select, highest priority first
	// ------------------------------------------------------------------
	always_comb begin
		w_upper	= '0;
		w_hit	= 1'b0;
		w_ram	= 1'b0;
		if (!w_cycle) begin
			// No memory cycle
		end
		else if (slot.sub3[0]) begin
			// Mapper RAM, all pages
			w_upper	= { 1'b1, segment, w_a13 };
			w_hit	= 1'b1;
			w_ram	= 1'b1;
		end
		else if (slot.sub0[2] && w_page == 2'd1) begin
			w_upper	= { MAP_MUSIC_ROM, w_a13 };		// MSX-MUSIC
			w_hit	= 1'b1;
		end
		else if (slot.sub3[1] && w_page == 2'd0) begin
			w_upper	= { MAP_SUB_ROM, w_a13 };		// SUB-ROM
			w_hit	= 1'b1;
		end
		else if (slot.sub0[0] && !w_page[1]) begin
			// MAIN-ROM 32KB, A14 comes from page LSB
			w_upper	= { MAP_MAIN_ROM, w_page[0], w_a13 };
			w_hit	= 1'b1;
		end
		else if (slot.sub3[2] && (w_page == 2'd1 || w_page == 2'd2)) begin
			w_upper	= { MAP_NEXTOR, w_page, w_a13 };	// Nextor banks
			w_hit	= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	//	Request
	// ------------------------------------------------------------------
	assign sdram.address	= { w_upper, bus.addr.mem.offset };
	assign sdram.mreq_n		= w_hit ? bus.mreq_n : 1'b1;
	assign sdram.rd_n		= w_hit ? bus.rd_n : 1'b1;
	assign sdram.wr_n		= (w_hit && w_ram) ? bus.wr_n : 1'b1;	// ROMs ignore writes
	assign sdram.wdata		= bus.wdata;

endmodule

//--- logic/msx_bus_glue.sv
// ----------------------------------------------------------------------
//	MSX bus glue top
//	Slot decode, SDRAM memory map and CPU read data return
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module msx_bus_glue (
	input							clk42m,
	input							ff_reset_n,
	input	msx_glue_pkg::cpu_bus_t		bus,
	input	msx_glue_pkg::rdata_t		sdram_q,
	input	msx_glue_pkg::rdata_t		io_q,
	output	msx_glue_pkg::sdram_req_t	sdram,
	output	msx_glue_pkg::io_sel_t		io_sel,
	output	logic	[7:0]				cpu_rdata
);
	import msx_glue_pkg::*;

	slot_sel_t		w_slot;				// Decoded slot for this access
	logic	[7:0]	w_segment;			// Mapper segment of current page
	rdata_t			w_reg_q;			// Own register readback

	// ------------------------------------------------------------------
	//	Slot and I/O decode
	// ------------------------------------------------------------------
	slot_decoder u_slot_decoder (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.bus			( bus			),
		.slot			( w_slot		),
		.segment		( w_segment		),
		.io_sel			( io_sel		),
		.reg_q			( w_reg_q		)
	);

	// ------------------------------------------------------------------
	//	SDRAM map
	// ------------------------------------------------------------------
	memory_map u_memory_map (
		.bus			( bus			),
		.slot			( w_slot		),
		.segment		( w_segment		),
		.sdram			( sdram			)
	);

	// ------------------------------------------------------------------
	//	Read data return
	// ------------------------------------------------------------------
	read_data_mux u_read_data_mux (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.rd_n			( bus.rd_n		),
		.sdram_q		( sdram_q		),
		.reg_q			( w_reg_q		),
		.io_q			( io_q			),
		.cpu_rdata		( cpu_rdata		)
	);

endmodule

//--- logic/msx_glue_pkg.sv
// ----------------------------------------------------------------------
//	MSX bus glue shared types
//	Z80 bus view, slot selection, SDRAM request and memory map constants
// ----------------------------------------------------------------------

package msx_glue_pkg;

	// ------------------------------------------------------------------
	//	Address views
	// ------------------------------------------------------------------
	typedef struct packed {
		logic	[1:0]	page;				// Z80 page, A15..A14
		logic			a13;				// Selects 8KB half of the page
		logic	[12:0]	offset;				// A12..A0
	} mem_addr_t;

	typedef struct packed {
		logic	[7:0]	upper;				// Not decoded for I/O
		logic	[7:0]	port;				// I/O port number
	} io_addr_t;

	typedef union packed {
		mem_addr_t		mem;
		io_addr_t		io;
	} msx_addr_u;

	// ------------------------------------------------------------------
	//	Bus bundles
	// ------------------------------------------------------------------
	typedef struct packed {
		msx_addr_u		addr;
		logic			mreq_n;
		logic			iorq_n;
		logic			rd_n;
		logic			wr_n;
		logic	[7:0]	wdata;
		logic			spare;				// Reserved
	} cpu_bus_t;

	typedef struct packed {
		logic	[3:0]	sltsl;				// Primary slot, one-hot
		logic	[3:0]	sub0;				// Slot 0-x, one-hot
		logic	[3:0]	sub3;				// Slot 3-x, one-hot
	} slot_sel_t;

	localparam int SDRAM_AW = 23;

	typedef struct packed {
		logic	[SDRAM_AW-1:0]	address;
		logic			rd_n;
		logic			wr_n;
		logic			mreq_n;
		logic	[7:0]	wdata;
	} sdram_req_t;

	typedef struct packed {
		logic			en;
		logic	[7:0]	data;
	} rdata_t;

	typedef struct packed {
		logic			vdp_cs_n;
		logic			psg_cs_n;
	} io_sel_t;

	// I/O ports
	localparam logic [7:0] PORT_PPI_BASE	= 8'hA8;
	localparam logic [7:0] PORT_PSG_BASE	= 8'hA0;	// A0h-A3h
	localparam logic [7:0] PORT_VDP_BASE	= 8'h98;	// 98h-99h
	localparam logic [7:0] PORT_MAPPER_BASE	= 8'hFC;	// FCh-FFh

	localparam logic [15:0] SUBSLOT_REG_ADDR = 16'hFFFF;

	// SDRAM upper address prefixes, A22 downwards
	localparam logic [7:0] MAP_MAIN_ROM		= 8'b0000_0100;		// + A14..A13
	localparam logic [8:0] MAP_SUB_ROM		= 9'b0_0001_0000;	// + A13
	localparam logic [8:0] MAP_MUSIC_ROM	= 9'b0_0000_1101;	// + A13
	localparam logic [6:0] MAP_NEXTOR		= 7'b000_0000;		// + A15..A13

	// Page 0 gets segment 3, page 3 gets segment 0
	localparam logic [3:0][7:0] MAPPER_RESET_SEG = {8'd0, 8'd1, 8'd2, 8'd3};

endpackage

//--- logic/read_data_mux.sv
// ----------------------------------------------------------------------
//	CPU read data mux
//	Registered priority select of the byte returned to the Z80
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module read_data_mux (
	input						clk42m,
	input						ff_reset_n,
	input						rd_n,
	input	msx_glue_pkg::rdata_t	sdram_q,
	input	msx_glue_pkg::rdata_t	reg_q,
	input	msx_glue_pkg::rdata_t	io_q,
	output	logic	[7:0]			cpu_rdata
);

	logic	[7:0]	ff_rdata;

	// ------------------------------------------------------------------
	//	SDRAM first, then own registers, then external I/O
	// ------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= 8'hFF;
		end
		else if (rd_n) begin
			ff_rdata <= 8'hFF;				// Pulled-up data bus
		end
		else if (sdram_q.en) begin
			ff_rdata <= sdram_q.data;
		end
		else if (reg_q.en) begin
			ff_rdata <= reg_q.data;			// Slot registers
		end
		else if (io_q.en) begin
			ff_rdata <= io_q.data;
		end
		else begin
			// Hold until a source answers
		end
	end

	assign cpu_rdata = ff_rdata;

endmodule

//--- logic/slot_decoder.sv
// ----------------------------------------------------------------------
//	Slot decoder
//	Primary/secondary slot registers, memory mapper segments and
//	I/O chip select decode
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module slot_decoder (
	input						clk42m,
	input						ff_reset_n,
	input	msx_glue_pkg::cpu_bus_t		bus,
	output	msx_glue_pkg::slot_sel_t	slot,
	output	logic	[7:0]				segment,
	output	msx_glue_pkg::io_sel_t		io_sel,
	output	msx_glue_pkg::rdata_t		reg_q
);
	import msx_glue_pkg::*;

	logic	[7:0]		ff_primary;			// Port A8h, 2 bits per page
	logic	[7:0]		ff_sub0;			// FFFFh in slot 0
	logic	[7:0]		ff_sub3;			// FFFFh in slot 3
	logic	[3:0][7:0]	ff_segment;			// Ports FCh-FFh

	logic				w_io_wr;
	logic				w_io_rd;
	logic				w_mem_cycle;
	logic				w_is_ppi;
	logic				w_is_mapper;
	logic				w_is_ffff;
	logic	[1:0]		w_page;
	logic	[1:0]		w_prim_slot;
	logic	[1:0]		w_page3_slot;		// Owner of FFFFh

	assign w_io_wr		= !bus.iorq_n && !bus.wr_n;
	assign w_io_rd		= !bus.iorq_n && !bus.rd_n;
	assign w_mem_cycle	= !bus.mreq_n;
	assign w_is_ppi		= (bus.addr.io.port == PORT_PPI_BASE);
	assign w_is_mapper	= ({ bus.addr.io.port[7:2], 2'b00 } == PORT_MAPPER_BASE);
	assign w_is_ffff	= (bus.addr == SUBSLOT_REG_ADDR);
	assign w_page		= bus.addr.mem.page;
	assign w_prim_slot	= ff_primary[{ w_page, 1'b0 } +: 2];
	assign w_page3_slot	= ff_primary[7:6];

	// ------------------------------------------------------------------
	//	Slot and mapper registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_primary	<= 8'h00;
			ff_sub0		<= 8'h00;
			ff_sub3		<= 8'h00;
			ff_segment	<= MAPPER_RESET_SEG;
		end
		else begin
			if (w_io_wr && w_is_ppi) begin
				ff_primary <= bus.wdata;
			end
			if (w_io_wr && w_is_mapper) begin
				ff_segment[bus.addr.io.port[1:0]] <= bus.wdata;	// Port low bits pick page
			end
			// Subslot register belongs to whichever slot owns page 3
			if (w_mem_cycle && !bus.wr_n && w_is_ffff) begin
				if (w_page3_slot == 2'd0) begin
					ff_sub0 <= bus.wdata;
				end
				else if (w_page3_slot == 2'd3) begin
					ff_sub3 <= bus.wdata;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	//	Slot selection for this access
	// ------------------------------------------------------------------
	assign slot.sltsl	= w_mem_cycle ? (4'b0001 << w_prim_slot) : 4'b0000;
	assign slot.sub0	= slot.sltsl[0] ? (4'b0001 << ff_sub0[{ w_page, 1'b0 } +: 2]) : 4'b0000;
	assign slot.sub3	= slot.sltsl[3] ? (4'b0001 << ff_sub3[{ w_page, 1'b0 } +: 2]) : 4'b0000;
	assign segment		= ff_segment[w_page];

	// Chip selects, active low
	assign io_sel.vdp_cs_n	= !(!bus.iorq_n && ({ bus.addr.io.port[7:1], 1'b0 } == PORT_VDP_BASE));
	assign io_sel.psg_cs_n	= !(!bus.iorq_n && ({ bus.addr.io.port[7:2], 2'b00 } == PORT_PSG_BASE));

	// Register readback
	always_comb begin
		reg_q = '{ en: 1'b0, data: 8'hFF };
		if (w_io_rd && w_is_ppi) begin
			reg_q = '{ en: 1'b1, data: ff_primary };
		end
		else if (w_mem_cycle && !bus.rd_n && w_is_ffff) begin
			if (w_page3_slot == 2'd0) begin
				reg_q = '{ en: 1'b1, data: ~ff_sub0 };		// Read back inverted
			end
			else if (w_page3_slot == 2'd3) begin
				reg_q = '{ en: 1'b1, data: ~ff_sub3 };
			end
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MSX bus glue testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f filelist.f --top-module msx_bus_glue_tb -o sim_msx_bus_glue

./obj_dir/sim_msx_bus_glue | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

//--- tests/bus_cases.txt
// op addr wdata sdram_q io_q | expect: strobes{mreq_n,rd_n,wr_n} sdram_addr io_sel{vdp,psg} rdata
// op 0 idle, 1 io wr, 2 io rd, 3 mem rd, 4 mem wr; sdram_q and io_q are {en, data}
0 0000 00 000 000  7 000000 3 FF
2 00A8 00 000 000  7 000000 3 00
3 FFFF 00 000 000  7 000000 3 FF
3 2000 00 1C3 000  1 022000 3 C3
3 7FFF 00 15A 000  1 027FFF 3 5A
1 00A8 FF 000 000  7 000000 3 FF
4 FFFF 00 000 000  7 000000 3 FF
1 00FE 25 000 000  7 000000 3 FF
4 8123 5A 000 000  2 494123 3 FF
3 8123 00 15A 000  1 494123 3 5A
4 FFFF 09 000 000  7 000000 3 FF
3 1234 00 1A5 000  1 041234 3 A5
3 6ABC 00 13C 000  1 006ABC 3 3C
3 FFFF 00 000 000  7 000000 3 F6
1 00A8 00 000 000  7 000000 3 FF
4 FFFF 0A 000 000  7 000000 3 FF
3 4100 00 177 000  1 034100 3 77
3 0100 00 000 000  7 000000 3 FF
3 FFFF 00 000 000  7 000000 3 F5
1 00A8 01 000 000  7 000000 3 FF
3 0000 00 000 000  7 000000 3 FF
2 0098 00 000 1B4  7 000000 1 B4
2 00A2 00 000 16E  7 000000 2 6E
3 4100 00 1E1 11F  1 034100 3 E1

//--- tests/msx_bus_glue_properties.sv
// ----------------------------------------------------------------------
//	MSX bus glue assertions
//	Chip select, SDRAM strobe and reset value checks on the top level
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module msx_bus_glue_properties (
	input							clk42m,
	input							ff_reset_n,
	input	msx_glue_pkg::slot_sel_t	slot,
	input	msx_glue_pkg::sdram_req_t	sdram,
	input	msx_glue_pkg::io_sel_t		io_sel,
	input	logic	[7:0]				cpu_rdata
);

	// Port ranges never overlap
	a_single_cs: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!(!io_sel.vdp_cs_n && !io_sel.psg_cs_n))
		else $error("VDP and PSG chip selects low together");

	a_rd_wr_exclusive: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!(!sdram.rd_n && !sdram.wr_n))
		else $error("SDRAM read and write strobes low together");

	// Only mapper RAM is writable
	a_write_mapper: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!sdram.wr_n |-> slot.sub3[0])
		else $error("SDRAM write outside slot 3-0");

	a_reset_rdata: assert property (@(posedge clk42m)
		!ff_reset_n |=> (cpu_rdata == 8'hFF))
		else $error("cpu_rdata not FFh after reset");

endmodule

//--- tests/msx_bus_glue_tb.sv
// ----------------------------------------------------------------------
//	MSX bus glue testbench
//	Replays bus operations from the case file and checks DUT responses
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module msx_bus_glue_tb;
	import msx_glue_pkg::*;

	localparam int			FIELDS		= 9;			// Words per case line
	localparam int			MAX_CASES	= 64;
	localparam logic [31:0]	NO_ENTRY	= 32'hFFFF_FFFF;	// Unread array slot

	// Operation codes of the case file
	localparam logic [31:0]	OP_IDLE		= 32'd0;
	localparam logic [31:0]	OP_IO_WR	= 32'd1;
	localparam logic [31:0]	OP_IO_RD	= 32'd2;
	localparam logic [31:0]	OP_MEM_RD	= 32'd3;
	localparam logic [31:0]	OP_MEM_WR	= 32'd4;

	logic			clk42m;
	logic			ff_reset_n;
	cpu_bus_t		bus;
	rdata_t			sdram_q;			// Modelled SDRAM return
	rdata_t			io_q;				// Modelled external I/O return
	sdram_req_t		sdram;
	io_sel_t		io_sel;
	logic	[7:0]	cpu_rdata;

	logic	[31:0]	case_mem [0:MAX_CASES*FIELDS-1];
	int				num_cases;
	int				errors;
	int				failed_tests;
	int				timeout_limit;
	int				cycle_count = 0;

	msx_bus_glue uut (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.bus			( bus			),
		.sdram_q		( sdram_q		),
		.io_q			( io_q			),
		.sdram			( sdram			),
		.io_sel			( io_sel		),
		.cpu_rdata		( cpu_rdata		)
	);

	// Assertions see the internal slot selection of the top
	bind msx_bus_glue msx_bus_glue_properties u_properties (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.slot			( w_slot		),
		.sdram			( sdram			),
		.io_sel			( io_sel		),
		.cpu_rdata		( cpu_rdata		)
	);

	initial begin
		clk42m = 1'b0;
		forever #50 clk42m = ~clk42m;		// 100 ns period
	end

	// Run limit
	always @(posedge clk42m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: simulation ran past %0d clock cycles", timeout_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	//	Helpers
	// ------------------------------------------------------------------
	// Z80 strobes for one operation code
	function automatic cpu_bus_t build_bus(input logic [31:0] op, input logic [31:0] addr,
			input logic [31:0] wdata);
		cpu_bus_t b;
		b			= '0;
		b.mreq_n	= 1'b1;
		b.iorq_n	= 1'b1;
		b.rd_n		= 1'b1;
		b.wr_n		= 1'b1;
		b.addr		= addr[15:0];			// Port sits in the low byte
		b.wdata		= wdata[7:0];
		case (op)
			OP_IO_WR: begin
				b.iorq_n	= 1'b0;
				b.wr_n		= 1'b0;
			end
			OP_IO_RD: begin
				b.iorq_n	= 1'b0;
				b.rd_n		= 1'b0;
			end
			OP_MEM_RD: begin
				b.mreq_n	= 1'b0;
				b.rd_n		= 1'b0;
			end
			OP_MEM_WR: begin
				b.mreq_n	= 1'b0;
				b.wr_n		= 1'b0;
			end
			default: begin
				// Idle bus
			end
		endcase
		return b;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	// Two strobe cycles, then one idle cycle
	task automatic run_case(input int idx);
		int				base;
		int				errors_before;
		logic	[31:0]	op;
		logic	[31:0]	strobes;
		base			= idx * FIELDS;
		errors_before	= errors;
		op				= case_mem[base];
		strobes			= case_mem[base+5];		// mreq_n, rd_n, wr_n
		@(posedge clk42m);
		bus		<= build_bus(op, case_mem[base+1], case_mem[base+2]);
		sdram_q	<= case_mem[base+3][8:0];
		io_q	<= case_mem[base+4][8:0];
		@(negedge clk42m);
		// Combinational side, before any register write lands
		check_value("sdram strobes", 32'({ sdram.mreq_n, sdram.rd_n, sdram.wr_n }), strobes);
		if (!strobes[2]) begin
			check_value("sdram address", 32'(sdram.address), case_mem[base+6]);
		end
		if (op == OP_MEM_WR) begin
			check_value("sdram wdata", 32'(sdram.wdata), case_mem[base+2]);
		end
		check_value("io selects", 32'(io_sel), case_mem[base+7]);
		check_value("cpu_rdata after idle", 32'(cpu_rdata), 32'h0000_00FF);
		@(posedge clk42m);
		@(negedge clk42m);
		check_value("cpu_rdata", 32'(cpu_rdata), case_mem[base+8]);	// Byte from first edge
		@(posedge clk42m);
		bus		<= build_bus(OP_IDLE, 32'd0, 32'd0);
		sdram_q	<= '0;
		io_q	<= '0;
		if (errors == errors_before) begin
			$display("Case %0d: op %0d at %h passed", idx, op, case_mem[base+1][15:0]);
		end
		else begin
			$display("Case %0d: op %0d at %h failed", idx, op, case_mem[base+1][15:0]);
			failed_tests = failed_tests + 1;
		end
	endtask

	// ------------------------------------------------------------------
	//	Main sequence
	// ------------------------------------------------------------------
	initial begin
		ff_reset_n		= 1'b0;
		bus				= build_bus(OP_IDLE, 32'd0, 32'd0);
		sdram_q			= '0;
		io_q			= '0;
		errors			= 0;
		failed_tests	= 0;
		for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
			case_mem[i] = NO_ENTRY;
		end
		$readmemh("tests/bus_cases.txt", case_mem);
		num_cases = 0;
		while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != NO_ENTRY) begin
			num_cases = num_cases + 1;
		end
		timeout_limit = num_cases * 3 + 20;
		if (num_cases == 0) begin
			$display("No cases could be read from tests/bus_cases.txt");
			errors = errors + 1;
		end
		repeat (3) @(posedge clk42m);
		ff_reset_n <= 1'b1;
		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end
		$display("Cases run: %0d, failed: %0d, mismatches: %0d", num_cases, failed_tests, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end
		else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
